/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int LINE_ADDR_W = 32;
    localparam int LINE_DATA_W = 64;
    localparam int REQ_TYPE_W = 2;
    localparam int REQ_HDR_W = REQ_TYPE_W + 2 + LINE_ADDR_W;

    // Virtual cache-line address
    typedef logic [LINE_ADDR_W-1:0] t_line_addr;
    // One line of data, narrowed from the full 512-bit line
    typedef logic [LINE_DATA_W-1:0] t_line_data;
    typedef logic [REQ_TYPE_W-1:0]  t_req_type;
    typedef logic [REQ_HDR_W-1:0]   t_req_hdr;
    // Lines in one run and acks completed in one cycle
    typedef logic [7:0]             t_line_count;
    typedef logic [1:0]             t_ack_count;

    // Request type codes
    localparam t_req_type REQ_RDLINE_S = 2'd0;
    localparam t_req_type REQ_RDLINE_I = 2'd1;
    localparam t_req_type REQ_WRLINE_M = 2'd2;
    localparam t_req_type REQ_WRLINE_I = 2'd3;

    // Header layout, type in the top bits and the address at the bottom
    localparam int HDR_TYPE_MSB = REQ_HDR_W - 1;
    localparam int HDR_TYPE_LSB = REQ_HDR_W - REQ_TYPE_W;
    localparam int HDR_ORDER_BIT = LINE_ADDR_W + 1;
    localparam int HDR_VADDR_BIT = LINE_ADDR_W;

    // Default request queue geometry
    localparam int QUEUE_DEPTH = 8;
    localparam int ALM_FULL_SLACK = 2;

    // Builds a request header; addresses are always virtual here
    function automatic t_req_hdr gen_req_hdr(input t_req_type rtype,
                                             input logic check_order,
                                             input t_line_addr addr);
        t_req_hdr hdr;
        hdr = '0;
        hdr[HDR_TYPE_MSB:HDR_TYPE_LSB] = rtype;
        hdr[HDR_ORDER_BIT] = check_order;
        hdr[HDR_VADDR_BIT] = 1'b1;
        hdr[LINE_ADDR_W-1:0] = addr;
        return hdr;
    endfunction

    // Expected content of a line, its address followed by the inverse
    function automatic t_line_data line_pattern(input t_line_addr addr);
        return {addr, ~addr};
    endfunction

endpackage

`default_nettype wire

/* hw/mem_tx_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_tx_queue
#(
    parameter int DEPTH = 8,
    parameter int SLACK = 2
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                push,
    input  mem_pkg::t_req_hdr   push_hdr,
    input  mem_pkg::t_line_data push_data,
    input  logic                plat_alm_full,
    output logic                alm_full,
    output logic                tx_valid,
    output mem_pkg::t_req_hdr   tx_hdr,
    output mem_pkg::t_line_data tx_data
);
    import mem_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_req_hdr         hdr_mem [DEPTH];
    t_line_data       data_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    // Pointers wrap explicitly so that DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // One entry leaves per cycle unless the platform is stalling us
    assign pop = (count != '0) && !plat_alm_full;

    // Ready drops early enough to absorb requests already in flight
    assign alm_full = (count >= CNT_W'(DEPTH - SLACK));

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            hdr_mem[wr_ptr] <= push_hdr;
            data_mem[wr_ptr] <= push_data;
        end
        // Registered output stage toward the platform
        if (pop)
        begin
            tx_hdr <= hdr_mem[rd_ptr];
            tx_data <= data_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            tx_valid <= 1'b0;
        end
        else
        begin
            tx_valid <= pop;
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // The client must have honored alm_full, so a full queue never takes a push
    assert property (@(posedge clk) disable iff (!reset_n)
                     push |-> (count != CNT_W'(DEPTH)) || pop)
        else $error("mem_tx_queue: push into a full queue");

endmodule

`default_nettype wire

/* hw/mem_drv.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_drv
(
    input  logic                 clk,
    input  logic                 reset_n,

    // ==============================
    // Client read side
    // ==============================
    input  mem_pkg::t_line_addr  mem_read_req_addr,
    // Use the platform cache when set
    input  logic                 mem_read_req_cached,
    // Keep loads and stores to one address in order
    input  logic                 mem_read_req_check_order,
    input  logic                 mem_read_req_enable,
    output logic                 mem_read_req_rdy,
    output mem_pkg::t_line_data  mem_read_rsp_data,
    output logic                 mem_read_rsp_rdy,

    // ==============================
    // Client write side
    // ==============================
    input  mem_pkg::t_line_addr  mem_write_addr,
    input  mem_pkg::t_line_data  mem_write_data,
    input  logic                 mem_write_req_cached,
    input  logic                 mem_write_req_check_order,
    input  logic                 mem_write_enable,
    output logic                 mem_write_rdy,
    // Writes completed this cycle, up to one per response channel
    output mem_pkg::t_ack_count  mem_write_ack,

    // Request queues
    output logic                 rd_push,
    output mem_pkg::t_req_hdr    rd_hdr,
    input  logic                 rd_alm_full,
    output logic                 wr_push,
    output mem_pkg::t_req_hdr    wr_hdr,
    output mem_pkg::t_line_data  wr_data,
    input  logic                 wr_alm_full,

    // Platform responses
    input  logic                 c0_rx_rd_valid,
    input  mem_pkg::t_line_data  c0_rx_data,
    input  logic                 c0_rx_wr_valid,
    input  logic                 c1_rx_wr_valid
);
    import mem_pkg::*;

    // Read requests go to channel 0 with a shared or invalid line type
    assign rd_push = mem_read_req_enable;
    assign rd_hdr = gen_req_hdr(mem_read_req_cached ? REQ_RDLINE_S : REQ_RDLINE_I,
                                mem_read_req_check_order,
                                mem_read_req_addr);
    assign mem_read_req_rdy = !rd_alm_full;

    // Responses arrive in request order, so they pass straight through
    assign mem_read_rsp_data = c0_rx_data;
    assign mem_read_rsp_rdy = c0_rx_rd_valid;

    // Write requests go to channel 1 together with their data
    assign wr_push = mem_write_enable;
    assign wr_hdr = gen_req_hdr(mem_write_req_cached ? REQ_WRLINE_M : REQ_WRLINE_I,
                                mem_write_req_check_order,
                                mem_write_addr);
    assign wr_data = mem_write_data;
    assign mem_write_rdy = !wr_alm_full;

    // Either response channel may carry a write ack, both in the same cycle
    assign mem_write_ack = t_ack_count'(c0_rx_wr_valid) + t_ack_count'(c1_rx_wr_valid);

    // The sequencer must wait for ready before it strobes a request
    assert property (@(posedge clk) disable iff (!reset_n)
                     mem_read_req_enable |-> mem_read_req_rdy)
        else $error("mem_drv: read request while not ready");

    assert property (@(posedge clk) disable iff (!reset_n)
                     mem_write_enable |-> mem_write_rdy)
        else $error("mem_drv: write request while not ready");

endmodule

`default_nettype wire

/* hw/mem_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_addr_gen
(
    input  logic                clk,
    input  logic                reset_n,
    input  mem_pkg::t_line_addr base_addr,
    // Reload the first line of the range
    input  logic                addr_restart,
    // Advance to the next line after a request was accepted
    input  logic                addr_step,
    output mem_pkg::t_line_addr line_addr,
    output mem_pkg::t_line_data line_data
);
    import mem_pkg::*;

    // Same counter serves the write phase and then the read phase
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            line_addr <= '0;
        end
        else if (addr_restart)
        begin
            line_addr <= base_addr;
        end
        else if (addr_step)
        begin
            line_addr <= line_addr + 1'b1;
        end
    end

    // Write data follows the address with no extra latency
    assign line_data = line_pattern(line_addr);

endmodule

`default_nettype wire

/* hw/mem_rsp_check.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_rsp_check
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  mem_pkg::t_line_addr  base_addr,
    input  logic                 addr_restart,
    input  logic                 rsp_valid,
    input  mem_pkg::t_line_data  rsp_data,
    output mem_pkg::t_line_count rsp_count,
    output mem_pkg::t_line_count err_count
);
    import mem_pkg::*;

    // Address of the line the next response belongs to
    t_line_addr exp_addr;
    logic       mismatch;

    // Responses come back in request order, so a plain counter tracks them
    assign mismatch = (rsp_data != line_pattern(exp_addr));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            exp_addr <= '0;
            rsp_count <= '0;
            err_count <= '0;
        end
        else if (addr_restart)
        begin
            // A new phase starts counting from the base of the range
            exp_addr <= base_addr;
            rsp_count <= '0;
            err_count <= '0;
        end
        else if (rsp_valid)
        begin
            exp_addr <= exp_addr + 1'b1;
            rsp_count <= rsp_count + 1'b1;
            if (mismatch)
                err_count <= err_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/mem_test_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_test_ctrl
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  mem_pkg::t_line_count num_lines,
    input  logic                 mem_read_req_rdy,
    input  logic                 mem_write_rdy,
    input  mem_pkg::t_ack_count  mem_write_ack,
    input  mem_pkg::t_line_count rsp_count,
    output logic                 mem_read_req_enable,
    output logic                 mem_write_enable,
    output logic                 addr_step,
    output logic                 addr_restart,
    output logic                 done
);
    import mem_pkg::*;

    typedef enum logic [2:0] {IDLE, WRITE, ACK_WAIT, READ, RSP_WAIT, DONE} t_state;

    t_state      state;
    t_state      state_next;
    t_line_count wr_issued;
    t_line_count rd_issued;
    t_line_count ack_total;
    logic        run_start;
    logic        acks_done;

    assign run_start = (state == IDLE) && start;
    assign acks_done = (state == ACK_WAIT) && (ack_total == num_lines);

    // One request per ready cycle until the range is covered
    assign mem_write_enable = (state == WRITE) && mem_write_rdy && (wr_issued != num_lines);
    assign mem_read_req_enable = (state == READ) && mem_read_req_rdy &&
                                 (rd_issued != num_lines);
    assign addr_step = mem_write_enable || mem_read_req_enable;

    // Addresses rewind at the start of the run and again before reading back
    assign addr_restart = run_start || acks_done;
    assign done = (state == DONE);

    // ==============================
    // Phase sequencing
    // ==============================

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (start)
                    state_next = WRITE;
            WRITE:
                if (wr_issued == num_lines)
                    state_next = ACK_WAIT;
            ACK_WAIT:
                if (acks_done)
                    state_next = READ;
            READ:
                if (rd_issued == num_lines)
                    state_next = RSP_WAIT;
            // The checker count lags a response by one cycle
            RSP_WAIT:
                if (rsp_count == num_lines)
                    state_next = DONE;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
            wr_issued <= '0;
            rd_issued <= '0;
            ack_total <= '0;
        end
        else
        begin
            state <= state_next;
            if (run_start)
            begin
                wr_issued <= '0;
                rd_issued <= '0;
                ack_total <= '0;
            end
            else
            begin
                // Acks may already arrive while writes are still going out
                ack_total <= ack_total + t_line_count'(mem_write_ack);
                if (mem_write_enable)
                    wr_issued <= wr_issued + 1'b1;
                if (mem_read_req_enable)
                    rd_issued <= rd_issued + 1'b1;
            end
        end
    end

    // The platform can only acknowledge writes that were actually sent
    assert property (@(posedge clk) disable iff (!reset_n) ack_total <= wr_issued)
        else $error("mem_test_ctrl: more write acks than writes issued");

endmodule

`default_nettype wire

/* hw/mem_test_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_test_top
#(
    parameter int Q_DEPTH = mem_pkg::QUEUE_DEPTH,
    parameter int Q_SLACK = mem_pkg::ALM_FULL_SLACK
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  logic                 cached,
    input  logic                 check_order,
    input  mem_pkg::t_line_addr  base_addr,
    input  mem_pkg::t_line_count num_lines,
    output logic                 done,
    output mem_pkg::t_line_count err_count,

    // Platform request channels
    output logic                 c0_tx_valid,
    output mem_pkg::t_req_hdr    c0_tx_hdr,
    input  logic                 c0_tx_alm_full,
    output logic                 c1_tx_valid,
    output mem_pkg::t_req_hdr    c1_tx_hdr,
    output mem_pkg::t_line_data  c1_tx_data,
    input  logic                 c1_tx_alm_full,

    // Platform response channels
    input  logic                 c0_rx_rd_valid,
    input  mem_pkg::t_line_data  c0_rx_data,
    input  logic                 c0_rx_wr_valid,
    input  logic                 c1_rx_wr_valid
);
    import mem_pkg::*;

    t_line_addr  line_addr;
    t_line_data  line_data;
    t_line_data  mem_read_rsp_data;
    t_ack_count  mem_write_ack;
    t_line_count rsp_count;
    t_req_hdr    rd_hdr;
    t_req_hdr    wr_hdr;
    t_line_data  wr_data;
    logic        mem_read_req_enable;
    logic        mem_read_req_rdy;
    logic        mem_write_enable;
    logic        mem_write_rdy;
    logic        mem_read_rsp_rdy;
    logic        addr_step;
    logic        addr_restart;
    logic        rd_push;
    logic        wr_push;
    logic        rd_alm_full;
    logic        wr_alm_full;

    // ==============================
    // Sequencing and datapath
    // ==============================

    mem_test_ctrl ctrl
    (
        .clk, .reset_n, .start, .num_lines,
        .mem_read_req_rdy, .mem_write_rdy, .mem_write_ack, .rsp_count,
        .mem_read_req_enable, .mem_write_enable, .addr_step, .addr_restart, .done
    );

    mem_addr_gen addr_gen
    (
        .clk, .reset_n, .base_addr, .addr_restart, .addr_step, .line_addr, .line_data
    );

    // Read responses from channel 0 feed the checker
    mem_rsp_check rsp_check
    (
        .clk, .reset_n, .base_addr, .addr_restart,
        .rsp_valid(mem_read_rsp_rdy), .rsp_data(mem_read_rsp_data),
        .rsp_count, .err_count
    );

    // Both phases share one address stream and the same run options
    mem_drv drv
    (
        .clk, .reset_n,
        .mem_read_req_addr(line_addr), .mem_read_req_cached(cached),
        .mem_read_req_check_order(check_order), .mem_read_req_enable,
        .mem_read_req_rdy, .mem_read_rsp_data, .mem_read_rsp_rdy,
        .mem_write_addr(line_addr), .mem_write_data(line_data),
        .mem_write_req_cached(cached), .mem_write_req_check_order(check_order),
        .mem_write_enable, .mem_write_rdy, .mem_write_ack,
        .rd_push, .rd_hdr, .rd_alm_full, .wr_push, .wr_hdr, .wr_data, .wr_alm_full,
        .c0_rx_rd_valid, .c0_rx_data, .c0_rx_wr_valid, .c1_rx_wr_valid
    );

    // ==============================
    // Request queues
    // ==============================

    // Channel 0 carries no payload, so its data path stays at zero
    mem_tx_queue #(.DEPTH(Q_DEPTH), .SLACK(Q_SLACK)) rd_queue
    (
        .clk, .reset_n, .push(rd_push), .push_hdr(rd_hdr), .push_data('0),
        .plat_alm_full(c0_tx_alm_full), .alm_full(rd_alm_full),
        .tx_valid(c0_tx_valid), .tx_hdr(c0_tx_hdr), .tx_data()
    );

    mem_tx_queue #(.DEPTH(Q_DEPTH), .SLACK(Q_SLACK)) wr_queue
    (
        .clk, .reset_n, .push(wr_push), .push_hdr(wr_hdr), .push_data(wr_data),
        .plat_alm_full(c1_tx_alm_full), .alm_full(wr_alm_full),
        .tx_valid(c1_tx_valid), .tx_hdr(c1_tx_hdr), .tx_data(c1_tx_data)
    );

endmodule

`default_nettype wire

/* dv/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
(
    input  logic                clk,
    input  logic                reset_n,
    // Raise platform almost-full at random on both channels
    input  logic                stall_en,
    // Let acks go out on both response channels in one cycle
    input  logic                dual_ack,
    // Read responses to lines with these low address bytes come back damaged
    input  logic [255:0]        corrupt_sel,
    input  logic                c0_tx_valid,
    input  mem_pkg::t_req_hdr   c0_tx_hdr,
    input  logic                c1_tx_valid,
    input  mem_pkg::t_req_hdr   c1_tx_hdr,
    input  mem_pkg::t_line_data c1_tx_data,
    output logic                c0_tx_alm_full,
    output logic                c1_tx_alm_full,
    output logic                c0_rx_rd_valid,
    output mem_pkg::t_line_data c0_rx_data,
    output logic                c0_rx_wr_valid,
    output logic                c1_rx_wr_valid,
    output int                  dual_ack_cycles
);
    import mem_pkg::*;

    t_line_data mem [t_line_addr];
    t_line_addr rd_addr_q[$];
    int         rd_due_q[$];
    int         wr_due_q[$];
    int         cycle;
    int         last_rd_due;
    int         due;
    int         idx;
    integer     seed;
    t_line_addr addr;
    t_line_data data;

    // Response latency of one to six cycles
    function automatic int rand_delay();
        return 1 + (($random(seed) & 32'h7fff_ffff) % 6);
    endfunction

    // Position of the first write whose ack is due, or -1
    function automatic int first_due();
        for (int i = 0; i < wr_due_q.size(); i++)
        begin
            if (wr_due_q[i] <= cycle)
                return i;
        end
        return -1;
    endfunction

    // ==============================
    // Platform behavior
    // ==============================

    // Everything happens on the falling edge, where the DUT outputs are settled
    initial
    begin
        seed = 34;
        cycle = 0;
        last_rd_due = 0;
        dual_ack_cycles = 0;
        c0_tx_alm_full = 1'b0;
        c1_tx_alm_full = 1'b0;
        c0_rx_rd_valid = 1'b0;
        c0_rx_data = '0;
        c0_rx_wr_valid = 1'b0;
        c1_rx_wr_valid = 1'b0;
        forever
        begin
            @(negedge clk);
            cycle++;
            c0_rx_rd_valid = 1'b0;
            c0_rx_wr_valid = 1'b0;
            c1_rx_wr_valid = 1'b0;
            if (!reset_n)
            begin
                rd_addr_q.delete();
                rd_due_q.delete();
                wr_due_q.delete();
                last_rd_due = cycle;
                c0_tx_alm_full = 1'b0;
                c1_tx_alm_full = 1'b0;
            end
            else
            begin
                // Writes land in the memory at once and are acked later
                if (c1_tx_valid)
                begin
                    mem[c1_tx_hdr[LINE_ADDR_W-1:0]] = c1_tx_data;
                    wr_due_q.push_back(cycle + rand_delay());
                end
                // Reads keep their order, so a late one holds back the ones behind it
                if (c0_tx_valid)
                begin
                    due = cycle + rand_delay();
                    if (due <= last_rd_due)
                        due = last_rd_due + 1;
                    last_rd_due = due;
                    rd_addr_q.push_back(c0_tx_hdr[LINE_ADDR_W-1:0]);
                    rd_due_q.push_back(due);
                end
                if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle)
                begin
                    addr = rd_addr_q.pop_front();
                    due = rd_due_q.pop_front();
                    // Lines never written read back as a fill derived from the address
                    data = mem.exists(addr) ? mem[addr] : {~addr, addr};
                    if (corrupt_sel[addr[7:0]])
                        data[0] = ~data[0];
                    c0_rx_rd_valid = 1'b1;
                    c0_rx_data = data;
                end
                // Channel 1 takes the first due ack, channel 0 a second one if free
                idx = first_due();
                if (idx >= 0)
                begin
                    wr_due_q.delete(idx);
                    c1_rx_wr_valid = 1'b1;
                    idx = first_due();
                    if (dual_ack && !c0_rx_rd_valid && idx >= 0)
                    begin
                        wr_due_q.delete(idx);
                        c0_rx_wr_valid = 1'b1;
                        dual_ack_cycles++;
                    end
                end
                // Half of the cycles stall while stalls are on
                c0_tx_alm_full = stall_en && ($random(seed) & 1);
                c1_tx_alm_full = stall_en && ($random(seed) & 1);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_mem_test.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_test;
    import mem_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MAX_LINES = 32;
    localparam int CLK_PERIOD = 8;

    logic         clk;
    logic         reset_n;
    logic         start;
    logic         cached;
    logic         check_order;
    t_line_addr   base_addr;
    t_line_count  num_lines;
    logic         done;
    t_line_count  err_count;
    logic         c0_tx_valid;
    t_req_hdr     c0_tx_hdr;
    logic         c0_tx_alm_full;
    logic         c1_tx_valid;
    t_req_hdr     c1_tx_hdr;
    t_line_data   c1_tx_data;
    logic         c1_tx_alm_full;
    logic         c0_rx_rd_valid;
    t_line_data   c0_rx_data;
    logic         c0_rx_wr_valid;
    logic         c1_rx_wr_valid;
    logic         stall_en;
    logic         dual_ack;
    logic [255:0] corrupt_sel;
    int           dual_ack_cycles;

    // Requests seen on the platform ports in the current run
    int           wr_seen;
    int           rd_seen;
    int           done_pulses;
    int           exp_errs;
    int           errors;
    int           tests_run;
    string        test_name;
    t_req_hdr     exp_wr_hdr;
    t_req_hdr     exp_rd_hdr;
    t_line_data   exp_wr_data;

    // Header layout is type, order flag, virtual flag, then the address
    function automatic t_req_hdr expect_hdr(input logic is_write, input logic use_cache,
                                            input logic order, input t_line_addr addr);
        t_req_type rtype;
        if (is_write)
            rtype = use_cache ? REQ_WRLINE_M : REQ_WRLINE_I;
        else
            rtype = use_cache ? REQ_RDLINE_S : REQ_RDLINE_I;
        return {rtype, order, 1'b1, addr};
    endfunction

    // A line holds its address followed by the inverted address
    function automatic t_line_data expect_line(input t_line_addr addr);
        return {addr, ~addr};
    endfunction

    task automatic report_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        errors++;
        $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_event(input string what);
        errors++;
        $display("%s: %s", test_name, what);
    endtask

    mem_test_top #(.Q_DEPTH(QUEUE_DEPTH), .Q_SLACK(ALM_FULL_SLACK)) UUT
    (
        .clk, .reset_n, .start, .cached, .check_order, .base_addr, .num_lines,
        .done, .err_count,
        .c0_tx_valid, .c0_tx_hdr, .c0_tx_alm_full,
        .c1_tx_valid, .c1_tx_hdr, .c1_tx_data, .c1_tx_alm_full,
        .c0_rx_rd_valid, .c0_rx_data, .c0_rx_wr_valid, .c1_rx_wr_valid
    );

    tb_mem_model model
    (
        .clk, .reset_n, .stall_en, .dual_ack, .corrupt_sel,
        .c0_tx_valid, .c0_tx_hdr, .c1_tx_valid, .c1_tx_hdr, .c1_tx_data,
        .c0_tx_alm_full, .c1_tx_alm_full,
        .c0_rx_rd_valid, .c0_rx_data, .c0_rx_wr_valid, .c1_rx_wr_valid,
        .dual_ack_cycles
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Request tracking
    // ==============================

    // Counters clear on start, which the DUT samples at the same edge
    always @(posedge clk)
    begin
        if (!reset_n || start)
        begin
            wr_seen <= 0;
            rd_seen <= 0;
            done_pulses <= 0;
        end
        else
        begin
            if (c1_tx_valid)
                wr_seen <= wr_seen + 1;
            if (c0_tx_valid)
                rd_seen <= rd_seen + 1;
            if (done)
                done_pulses <= done_pulses + 1;
        end
    end

    // The next request on each channel belongs to the next line of the range
    always_comb
    begin
        exp_wr_hdr = expect_hdr(1'b1, cached, check_order, base_addr + t_line_addr'(wr_seen));
        exp_rd_hdr = expect_hdr(1'b0, cached, check_order, base_addr + t_line_addr'(rd_seen));
        exp_wr_data = expect_line(base_addr + t_line_addr'(wr_seen));
    end

    // ==============================
    // Checks
    // ==============================

    assert property (@(posedge clk) disable iff (!reset_n) c1_tx_valid |-> c1_tx_hdr == exp_wr_hdr)
        else report_value("c1_tx_hdr", $sampled(exp_wr_hdr), $sampled(c1_tx_hdr));

    assert property (@(posedge clk) disable iff (!reset_n)
                     c1_tx_valid |-> c1_tx_data == exp_wr_data)
        else report_value("c1_tx_data", $sampled(exp_wr_data), $sampled(c1_tx_data));

    assert property (@(posedge clk) disable iff (!reset_n) c0_tx_valid |-> c0_tx_hdr == exp_rd_hdr)
        else report_value("c0_tx_hdr", $sampled(exp_rd_hdr), $sampled(c0_tx_hdr));

    // Totals at the end of a run
    assert property (@(posedge clk) disable iff (!reset_n) done |-> wr_seen == num_lines)
        else report_value("write count", $sampled(num_lines), $sampled(wr_seen));

    assert property (@(posedge clk) disable iff (!reset_n) done |-> rd_seen == num_lines)
        else report_value("read count", $sampled(num_lines), $sampled(rd_seen));

    assert property (@(posedge clk) disable iff (!reset_n) done |-> err_count == exp_errs)
        else report_value("err_count", $sampled(exp_errs), $sampled(err_count));

    assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
        else report_event("done stayed high for more than one cycle");

    // A stalled channel may still finish the transfer that is already under way
    assert property (@(posedge clk) disable iff (!reset_n) c0_tx_alm_full |=> !c0_tx_valid)
        else report_event("c0_tx_valid rose while the platform held c0 almost full");

    assert property (@(posedge clk) disable iff (!reset_n) c1_tx_alm_full |=> !c1_tx_valid)
        else report_event("c1_tx_valid rose while the platform held c1 almost full");

    // ==============================
    // Stimulus
    // ==============================

    task automatic run_test(input string name, input logic use_cache, input logic order,
                            input t_line_addr base, input int lines, input int corrupted);
        int errors_before;
        errors_before = errors;
        test_name = name;
        cached = use_cache;
        check_order = order;
        base_addr = base;
        num_lines = t_line_count'(lines);
        exp_errs = corrupted;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        // A few idle cycles show whether done comes back
        repeat (4) @(negedge clk);
        assert (done_pulses == 1)
            else report_value("done pulses", 1, done_pulses);
        // Only the dual ack run has to show acks on both channels at once
        if (dual_ack)
            assert (dual_ack_cycles > 0)
                else report_event("the model never acked on both channels in one cycle");
        tests_run++;
        if (errors == errors_before)
            $display("test %s passed", name);
        else
            $display("test %s failed with %0d errors", name, errors - errors_before);
    endtask

    initial
    begin
        errors = 0;
        tests_run = 0;
        test_name = "reset";
        reset_n = 1'b0;
        start = 1'b0;
        cached = 1'b0;
        check_order = 1'b0;
        base_addr = '0;
        num_lines = '0;
        stall_en = 1'b0;
        dual_ack = 1'b0;
        corrupt_sel = '0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        run_test("clean_cached", 1'b1, 1'b0, 32'h0000_1000, 16, 0);
        // The range wraps past the top of the address space
        run_test("clean_uncached_wrap", 1'b0, 1'b1, 32'hffff_fff0, MAX_LINES, 0);

        // Three lines of the range come back damaged
        corrupt_sel[8'h43] = 1'b1;
        corrupt_sel[8'h4a] = 1'b1;
        corrupt_sel[8'h57] = 1'b1;
        run_test("corrupt_reads", 1'b1, 1'b1, 32'h2000_0040, 24, 3);
        corrupt_sel = '0;

        stall_en = 1'b1;
        run_test("platform_stall", 1'b0, 1'b0, 32'h0003_0000, MAX_LINES, 0);
        stall_en = 1'b0;

        dual_ack = 1'b1;
        run_test("dual_acks", 1'b1, 1'b0, 32'h0000_8000, MAX_LINES, 0);
        dual_ack = 1'b0;

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Twenty cycles per line of every test covers the slowest stalled run
    initial
    begin
        repeat (NUM_TESTS * MAX_LINES * 20) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/mem_pkg.sv
hw/mem_tx_queue.sv
hw/mem_drv.sv
hw/mem_addr_gen.sv
hw/mem_rsp_check.sv
hw/mem_test_ctrl.sv
hw/mem_test_top.sv
dv/tb_mem_model.sv
dv/tb_mem_test.sv

/* Bender.yml */
package:
  name: mem_test

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/mem_tx_queue.sv
      - hw/mem_drv.sv
      - hw/mem_addr_gen.sv
      - hw/mem_rsp_check.sv
      - hw/mem_test_ctrl.sv
      - hw/mem_test_top.sv
  - target: simulation
    files:
      - dv/tb_mem_model.sv
      - dv/tb_mem_test.sv
